//--- files.f
+incdir+common
common/rv_pkg.sv
common/regfile_if.sv
verilog/reg_file.sv
core/decoder.sv
core/alu.sv
core/sequencer.sv
core/rv_core.sv
tests/rv_core_properties.sv
tests/rv_core_tb.sv

//--- Makefile
# Verilator build for the rv32i core and its testbench

VERILATOR ?= verilator
FILELIST  ?= files.f
TOP       ?= rv_core_tb
LINT_TOP  ?= rv_core
BUILD_DIR ?= obj_dir
VFLAGS    ?= --assert --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- tests/rv_core_tb.sv
/*
  testbench for the rv32i multicycle core
  Wishbone memory with random ack delay, a table of small programs
  with expected results, run loop and result checks
*/
`default_nettype none

`include "rv_consts.svh"

module rv_core_tb;
  import rv_pkg::*;

  localparam int NUM_ROWS = 31;
  localparam int ROW_LEN  = 8;
  localparam int WATCHDOG = NUM_ROWS * ROW_LEN * 12 * 20;
  localparam insn_t ECALL = 32'h0000_0073;
  localparam insn_t FENCE = 32'h0ff0_000f;
  localparam insn_t NOP   = 32'h0000_0013;

  logic  clk = 1'b0;
  logic  rst;
  word_t wb_adr;
  word_t wb_dat_w;
  word_t wb_dat_r = '0;
  logic  wb_we;
  logic  wb_cyc;
  logic  wb_stb;
  logic  wb_ack = 1'b0;
  logic  halt;

  word_t mem [64];
  word_t write_log [$];
  logic  pending;
  int    delay;
  logic  seen_first;
  word_t first_adr;
  logic  first_we;

  insn_t prog [NUM_ROWS][ROW_LEN];
  word_t d0 [NUM_ROWS];
  word_t d1 [NUM_ROWS];
  word_t expv [NUM_ROWS];
  int    n_rows;
  int    pos;

  rv_core u_rv_core (
    .clk      (clk),
    .rst      (rst),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_we    (wb_we),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_ack   (wb_ack),
    .halt     (halt)
  );

  always #10 clk = ~clk;

  // program words at 0x000, data words at 0x100, 32 of each
  function automatic int mem_index(word_t adr);
    return int'({adr[8], adr[6:2]});
  endfunction

  // slave acks 1 to 4 cycles after it sees the request
  always @(negedge clk) begin
    if (rst) begin
      wb_ack  = 1'b0;
      pending = 1'b0;
    end else if (wb_ack) begin
      wb_ack  = 1'b0;
      pending = 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!pending) begin
        pending = 1'b1;
        delay   = 1 + int'($urandom() % 4);
        if (!seen_first) begin
          seen_first = 1'b1;
          first_adr  = wb_adr;
          first_we   = wb_we;
        end
      end
      delay = delay - 1;
      if (delay == 0) begin
        wb_ack = 1'b1;
        if (wb_we) begin
          mem[mem_index(wb_adr)] = wb_dat_w;
          write_log.push_back(wb_adr);
        end else begin
          wb_dat_r = mem[mem_index(wb_adr)];
        end
      end
    end
  end

  initial begin
    #(WATCHDOG);
    $display("timeout: the core did not finish the program table in time");
    $display(">>> FAIL");
    $fatal(1);
  end

  task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
      $display(">>> FAIL");
      $fatal(1);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s got %b expected %b", $time, what, got, exp);
      $display(">>> FAIL");
      $fatal(1);
    end
  endtask

  // instruction encoders
  function automatic insn_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [2:0] f3, reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
  endfunction

  function automatic insn_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                  reg_idx_t rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic insn_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RV_OP_STORE};
  endfunction

  function automatic insn_t enc_b(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
  endfunction

  function automatic insn_t enc_j(logic [20:0] imm, reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
  endfunction

  // reference results straight from the ISA definitions
  function automatic word_t ref_alu(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic ref_taken(logic [2:0] f3, word_t a, word_t b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic put(input insn_t w);
    prog[n_rows][pos] = w;
    pos = pos + 1;
  endtask

  task automatic end_row(input word_t a, input word_t b, input word_t e);
    d0[n_rows]   = a;
    d1[n_rows]   = b;
    expv[n_rows] = e;
    n_rows = n_rows + 1;
    pos    = 0;
  endtask

  task automatic build_table();
    logic [2:0]  f3s [6];
    logic [11:0] imm;
    word_t       a;
    word_t       b;
    word_t       u;
    f3s = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    n_rows = 0;
    pos    = 0;
    foreach (prog[r, k]) prog[r][k] = ECALL;
    // reg-reg ops for f3 0..7, plus sub and sra
    for (int k = 0; k < 10; k++) begin
      a = $urandom();
      b = $urandom();
      put(enc_i(12'h100, 5'd0, 3'b010, 5'd1, `RV_OP_LOAD));
      put(enc_i(12'h104, 5'd0, 3'b010, 5'd2, `RV_OP_LOAD));
      put(enc_r((k >= 8) ? 7'h20 : 7'h00, 5'd2, 5'd1, (k == 8) ? 3'd0 : (k == 9) ? 3'd5 : k[2:0],
                5'd3));
      put(enc_s(12'h108, 5'd3, 5'd0));
      end_row(a, b, ref_alu((k == 8) ? 3'd0 : (k == 9) ? 3'd5 : k[2:0], k >= 8, a, b));
    end
    // reg-imm ops for f3 0..7 and srai
    for (int k = 0; k < 9; k++) begin
      a   = $urandom();
      imm = 12'($urandom());
      if (k == 1 || k == 5) imm = {7'h00, imm[4:0]};
      if (k == 8) imm = {7'h20, imm[4:0]};
      put(enc_i(12'h100, 5'd0, 3'b010, 5'd1, `RV_OP_LOAD));
      put(enc_i(imm, 5'd1, (k == 8) ? 3'd5 : k[2:0], 5'd3, `RV_OP_IMM));
      put(enc_s(12'h108, 5'd3, 5'd0));
      end_row(a, 0, ref_alu((k == 8) ? 3'd5 : k[2:0], k == 8, a, {{20{imm[11]}}, imm}));
    end
    // a write to x0 leaves it zero
    put(enc_i(12'h100, 5'd0, 3'b010, 5'd1, `RV_OP_LOAD));
    put(enc_r(7'h00, 5'd1, 5'd1, 3'd0, 5'd0));
    put(enc_s(12'h108, 5'd0, 5'd0));
    end_row($urandom() | 1, 0, 0);
    u = $urandom();
    put({u[19:0], 5'd3, `RV_OP_LUI});
    put(enc_s(12'h108, 5'd3, 5'd0));
    end_row(0, 0, {u[19:0], 12'h000});
    put(NOP);
    put({u[31:12], 5'd3, `RV_OP_AUIPC});
    put(enc_s(12'h108, 5'd3, 5'd0));
    end_row(0, 0, 32'd4 + {u[31:12], 12'h000});
    // branches write 0x5a1 when taken, 0x2b3 when not
    for (int k = 0; k < 6; k++) begin
      a = $urandom();
      b = k[0] ? a : $urandom();
      put(enc_i(12'h100, 5'd0, 3'b010, 5'd1, `RV_OP_LOAD));
      put(enc_i(12'h104, 5'd0, 3'b010, 5'd2, `RV_OP_LOAD));
      put(enc_b(13'd12, 5'd2, 5'd1, f3s[k]));
      put(enc_i(12'h2b3, 5'd0, 3'd0, 5'd3, `RV_OP_IMM));
      put(enc_j(21'd8, 5'd0));
      put(enc_i(12'h5a1, 5'd0, 3'd0, 5'd3, `RV_OP_IMM));
      put(enc_s(12'h108, 5'd3, 5'd0));
      end_row(a, b, ref_taken(f3s[k], a, b) ? 32'h5a1 : 32'h2b3);
    end
    // jal at 4 links 8 and skips the overwrite
    put(NOP);
    put(enc_j(21'd8, 5'd3));
    put(enc_i(12'h001, 5'd0, 3'd0, 5'd3, `RV_OP_IMM));
    put(enc_s(12'h108, 5'd3, 5'd0));
    end_row(0, 0, 32'd8);
    // jalr at 4 jumps to 16
    put(enc_i(12'd16, 5'd0, 3'd0, 5'd1, `RV_OP_IMM));
    put(enc_i(12'd0, 5'd1, 3'd0, 5'd3, `RV_OP_JALR));
    put(enc_i(12'h001, 5'd0, 3'd0, 5'd3, `RV_OP_IMM));
    put(ECALL);
    put(enc_s(12'h108, 5'd3, 5'd0));
    end_row(0, 0, 32'd8);
    put(enc_i(12'h100, 5'd0, 3'b010, 5'd1, `RV_OP_LOAD));
    put(FENCE);
    put(enc_s(12'h108, 5'd1, 5'd0));
    u = $urandom();
    end_row(u, 0, u);
  endtask

  task automatic load_memory(input int r);
    word_t addr;
    for (int i = 0; i < 64; i++) begin
      addr   = (i >= 32) ? 32'h100 + (i - 32) * 4 : i * 4;
      mem[i] = ~(addr * 32'h9e37_79b9);
    end
    for (int k = 0; k < ROW_LEN; k++) begin
      mem[k] = prog[r][k];
    end
    mem[mem_index(32'h100)] = d0[r];
    mem[mem_index(32'h104)] = d1[r];
    write_log.delete();
    seen_first = 1'b0;
  endtask

  task automatic run_row(input int r);
    rst = 1'b1;
    load_memory(r);
    repeat (5) @(negedge clk);
    rst = 1'b0;
    check_flag("halt after reset", halt, 1'b0);
    check_flag("cyc after reset", wb_cyc, 1'b0);
    check_flag("stb after reset", wb_stb, 1'b0);
    check_flag("we after reset", wb_we, 1'b0);
    while (!halt) @(negedge clk);
    // halted core stays parked with the bus idle
    repeat (4) begin
      @(negedge clk);
      check_flag("halt held", halt, 1'b1);
      check_flag("cyc while halted", wb_cyc, 1'b0);
      check_flag("stb while halted", wb_stb, 1'b0);
    end
    check_word("first bus address", first_adr, `RV_RESET_PC);
    check_flag("first bus cycle is a read", first_we, 1'b0);
    check_word("write count", word_t'(write_log.size()), 32'd1);
    check_word("write address", write_log[0], 32'h108);
    check_word("stored result", mem[mem_index(32'h108)], expv[r]);
  endtask

  initial begin
    rst = 1'b1;
    void'($urandom(32'h264eff31));
    build_table();
    if (n_rows != NUM_ROWS) begin
      $display("program table has %0d rows instead of %0d", n_rows, NUM_ROWS);
      $display(">>> FAIL");
      $fatal(1);
    end
    @(negedge clk);
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/rv_core_properties.sv
/*
  Wishbone and halt assertions for the rv32i core
  bound to every rv_core instance
*/
`default_nettype none

module rv_core_properties (
  input logic          clk,
  input logic          rst,
  input rv_pkg::word_t wb_adr,
  input rv_pkg::word_t wb_dat_w,
  input logic          wb_we,
  input logic          wb_cyc,
  input logic          wb_stb,
  input logic          wb_ack,
  input logic          halt
);
  import rv_pkg::*;

  a_stb_needs_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
    else $error("stb high without cyc");

  // request fields hold until the slave acks
  a_request_stable: assert property (@(posedge clk) disable iff (rst)
    (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w)))
    else $error("bus request changed before ack");

  a_word_aligned: assert property (@(posedge clk) disable iff (rst)
    wb_cyc |-> (wb_adr[1:0] == 2'b00))
    else $error("unaligned bus address");

  a_no_cyc_halted: assert property (@(posedge clk) disable iff (rst) halt |-> !wb_cyc)
    else $error("bus cycle while halted");

  a_halt_sticks: assert property (@(posedge clk) disable iff (rst) halt |=> halt)
    else $error("halt dropped without reset");

endmodule

bind rv_core rv_core_properties u_rv_core_properties (
  .clk      (clk),
  .rst      (rst),
  .wb_adr   (wb_adr),
  .wb_dat_w (wb_dat_w),
  .wb_we    (wb_we),
  .wb_cyc   (wb_cyc),
  .wb_stb   (wb_stb),
  .wb_ack   (wb_ack),
  .halt     (halt)
);

`default_nettype wire

//--- core/rv_core.sv
/*
  rv32i multicycle core
  sequencer, decoder, ALU and register file behind one
  Wishbone classic master port
*/
`default_nettype none

module rv_core (
  input  logic          clk,
  input  logic          rst,
  output rv_pkg::word_t wb_adr,
  output rv_pkg::word_t wb_dat_w,
  input  rv_pkg::word_t wb_dat_r,
  output logic          wb_we,
  output logic          wb_cyc,
  output logic          wb_stb,
  input  logic          wb_ack,
  output logic          halt
);
  import rv_pkg::*;

  insn_t   ir;
  word_t   imm;
  word_t   alu_a;
  word_t   alu_b;
  word_t   alu_result;
  alu_op_e alu_op;
  logic    use_imm;
  logic    is_load;
  logic    is_store;
  logic    is_branch;
  logic    is_jal;
  logic    is_jalr;
  logic    is_auipc;
  logic    is_ecall;
  logic    writes_rd;

  regfile_if rf_bus ();

  sequencer u_sequencer (
    .clk        (clk),
    .rst        (rst),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .imm        (imm),
    .use_imm    (use_imm),
    .is_load    (is_load),
    .is_store   (is_store),
    .is_branch  (is_branch),
    .is_jal     (is_jal),
    .is_jalr    (is_jalr),
    .is_auipc   (is_auipc),
    .is_ecall   (is_ecall),
    .writes_rd  (writes_rd),
    .alu_result (alu_result),
    .ir         (ir),
    .alu_a      (alu_a),
    .alu_b      (alu_b),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_we      (wb_we),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .halt       (halt),
    .rf         (rf_bus.client)
  );

  decoder u_decoder (
    .ir        (ir),
    .imm       (imm),
    .alu_op    (alu_op),
    .use_imm   (use_imm),
    .is_load   (is_load),
    .is_store  (is_store),
    .is_branch (is_branch),
    .is_jal    (is_jal),
    .is_jalr   (is_jalr),
    .is_auipc  (is_auipc),
    .is_ecall  (is_ecall),
    .writes_rd (writes_rd)
  );

  alu u_alu (
    .a      (alu_a),
    .b      (alu_b),
    .op     (alu_op),
    .result (alu_result)
  );

  reg_file u_reg_file (
    .clk (clk),
    .rst (rst),
    .rf  (rf_bus.rf)
  );

endmodule

`default_nettype wire

//--- core/sequencer.sv
/*
  multicycle sequencer
  fetch, exec and mem states, program counter, instruction register,
  register writeback and the Wishbone classic master
*/
`default_nettype none

`include "rv_consts.svh"

module sequencer (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::word_t    wb_dat_r,
  input  logic             wb_ack,
  input  rv_pkg::word_t    imm,
  input  logic             use_imm,
  input  logic             is_load,
  input  logic             is_store,
  input  logic             is_branch,
  input  logic             is_jal,
  input  logic             is_jalr,
  input  logic             is_auipc,
  input  logic             is_ecall,
  input  logic             writes_rd,
  input  rv_pkg::word_t    alu_result,
  output rv_pkg::insn_t    ir,
  output rv_pkg::word_t    alu_a,
  output rv_pkg::word_t    alu_b,
  output rv_pkg::word_t    wb_adr,
  output rv_pkg::word_t    wb_dat_w,
  output logic             wb_we,
  output logic             wb_cyc,
  output logic             wb_stb,
  output logic             halt,
  regfile_if.client        rf
);
  import rv_pkg::*;

  core_state_e state;
  word_t       pc;
  word_t       pc_plus4;
  word_t       pc_plus_imm;
  word_t       pc_next;
  logic        bus_done;

  assign pc_plus4    = pc + `RV_XLEN'd4;
  assign pc_plus_imm = pc + imm;
  assign bus_done    = wb_cyc && wb_ack;
  assign halt        = (state == st_halted);

  // taken branches reuse the compare result in bit 0
  always_comb begin
    if (is_jal || (is_branch && alu_result[0])) begin
      pc_next = pc_plus_imm;
    end else if (is_jalr) begin
      pc_next = {alu_result[`RV_XLEN-1:1], 1'b0};
    end else begin
      pc_next = pc_plus4;
    end
  end

  assign rf.rs1_idx = ir[19:15];
  assign rf.rs2_idx = ir[24:20];
  assign rf.rd_idx  = ir[11:7];
  assign alu_a      = rf.rs1_data;
  assign alu_b      = use_imm ? imm : rf.rs2_data;

  always_comb begin
    if (state == st_mem) begin
      rf.rd_data = wb_dat_r;
    end else if (is_auipc) begin
      rf.rd_data = pc_plus_imm;
    end else if (is_jal || is_jalr) begin
      rf.rd_data = pc_plus4;
    end else begin
      rf.rd_data = alu_result;
    end
  end

  // loads write back when the data phase acks, everything else in exec
  assign rf.we = ((state == st_exec) && writes_rd && !is_load) ||
                 ((state == st_mem) && bus_done && is_load);

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= st_fetch;
      pc     <= `RV_RESET_PC;
      wb_adr <= `RV_RESET_PC;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
    end else begin
      case (state)
        st_fetch: begin
          if (!wb_cyc) begin
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
            wb_adr <= {pc[`RV_XLEN-1:2], 2'b00};
          end else if (wb_ack) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            state  <= st_exec;
          end
        end
        st_exec: begin
          if (is_ecall) begin
            state <= st_halted;
          end else if (is_load || is_store) begin
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
            wb_we  <= is_store;
            wb_adr <= {alu_result[`RV_XLEN-1:2], 2'b00};
            state  <= st_mem;
          end else begin
            // next fetch starts straight away
            pc     <= pc_next;
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
            wb_adr <= {pc_next[`RV_XLEN-1:2], 2'b00};
            state  <= st_fetch;
          end
        end
        st_mem: begin
          if (wb_ack) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
            pc     <= pc_plus4;
            state  <= st_fetch;
          end
        end
        st_halted: begin
          // parked until reset
          state <= st_halted;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == st_fetch) && bus_done) begin
      ir <= wb_dat_r;
    end
    if ((state == st_exec) && is_store) begin
      wb_dat_w <= rf.rs2_data;
    end
  end

endmodule

`default_nettype wire

//--- core/alu.sv
/*
  integer ALU
  add, sub, shifts, logic ops and the compares used by
  slt and the conditional branches
*/
`default_nettype none

module alu (
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  input  rv_pkg::alu_op_e op,
  output rv_pkg::word_t   result
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = b[4:0];
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;

  always_comb begin
    case (op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_sll:    result = a << shamt;
      alu_srl:    result = a >> shamt;
      alu_sra:    result = word_t'($signed(a) >>> shamt);
      alu_slt:    result = word_t'(lt_s);
      alu_sltu:   result = word_t'(lt_u);
      alu_xor:    result = a ^ b;
      alu_or:     result = a | b;
      alu_and:    result = a & b;
      alu_pass_b: result = b;
      alu_eq:     result = word_t'(a == b);
      alu_ne:     result = word_t'(a != b);
      alu_lt:     result = word_t'(lt_s);
      alu_ge:     result = word_t'(!lt_s);
      alu_ltu:    result = word_t'(lt_u);
      default:    result = word_t'(!lt_u);
    endcase
  end

endmodule

`default_nettype wire

//--- core/decoder.sv
/*
  instruction decoder
  builds the immediate, picks the ALU operation and raises the
  class flag of the instruction held in the instruction register
*/
`default_nettype none

`include "rv_consts.svh"

module decoder (
  input  rv_pkg::insn_t   ir,
  output rv_pkg::word_t   imm,
  output rv_pkg::alu_op_e alu_op,
  output logic            use_imm,
  output logic            is_load,
  output logic            is_store,
  output logic            is_branch,
  output logic            is_jal,
  output logic            is_jalr,
  output logic            is_auipc,
  output logic            is_ecall,
  output logic            writes_rd
);
  import rv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       is_lui;
  logic       is_reg;
  logic       alu_ok;

  assign opcode = ir[6:0];
  assign funct3 = ir[14:12];
  assign funct7 = ir[31:25];

  // only word loads and stores exist here
  assign is_load   = (opcode == `RV_OP_LOAD) && (funct3 == 3'b010);
  assign is_store  = (opcode == `RV_OP_STORE) && (funct3 == 3'b010);
  assign is_branch = (opcode == `RV_OP_BRANCH) && (funct3[2:1] != 2'b01);
  assign is_jal    = (opcode == `RV_OP_JAL);
  assign is_jalr   = (opcode == `RV_OP_JALR) && (funct3 == 3'b000);
  assign is_auipc  = (opcode == `RV_OP_AUIPC);
  assign is_ecall  = (opcode == `RV_OP_SYSTEM) && (ir[31:7] == '0);
  assign is_lui    = (opcode == `RV_OP_LUI);
  assign is_reg    = (opcode == `RV_OP_REG);
  assign use_imm   = !is_reg && (opcode != `RV_OP_BRANCH);
  assign writes_rd = is_load | is_jal | is_jalr | is_auipc | is_lui | alu_ok;

  always_comb begin
    case (opcode)
      `RV_OP_STORE:             imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
      `RV_OP_BRANCH:            imm = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
      `RV_OP_LUI, `RV_OP_AUIPC: imm = {ir[31:12], 12'b0};
      `RV_OP_JAL:               imm = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
      default:                  imm = {{20{ir[31]}}, ir[31:20]};
    endcase
  end

  // loads, stores and jalr fall through to add for the address sum
  always_comb begin
    alu_op = alu_add;
    alu_ok = 1'b0;
    case (opcode)
      `RV_OP_LUI: alu_op = alu_pass_b;
      `RV_OP_BRANCH: begin
        case (funct3)
          3'b000:  alu_op = alu_eq;
          3'b001:  alu_op = alu_ne;
          3'b100:  alu_op = alu_lt;
          3'b101:  alu_op = alu_ge;
          3'b110:  alu_op = alu_ltu;
          default: alu_op = alu_geu;
        endcase
      end
      `RV_OP_IMM, `RV_OP_REG: begin
        case (funct3)
          3'b000:  alu_op = (is_reg && funct7[5]) ? alu_sub : alu_add;
          3'b001:  alu_op = alu_sll;
          3'b010:  alu_op = alu_slt;
          3'b011:  alu_op = alu_sltu;
          3'b100:  alu_op = alu_xor;
          3'b110:  alu_op = alu_or;
          3'b111:  alu_op = alu_and;
          default: alu_op = funct7[5] ? alu_sra : alu_srl;
        endcase
        // funct7 is zero, or 0100000 for sub, sra and srai
        alu_ok = (!is_reg && (funct3[1:0] != 2'b01)) || (funct7 == 7'h00) ||
                 ((funct7 == 7'h20) && ((funct3 == 3'b101) || (is_reg && funct3 == 3'b000)));
      end
      // one in-order hart, so fence has nothing to order
      `RV_OP_FENCE: alu_ok = 1'b0;
      default: alu_ok = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
/*
  integer register file
  32 words, two combinational reads, one write per clock,
  x0 always reads as zero
*/
`default_nettype none

`include "rv_consts.svh"

module reg_file (
  input logic   clk,
  input logic   rst,
  regfile_if.rf rf
);
  import rv_pkg::*;

  word_t regs [`RV_NUM_REGS];

  assign rf.rs1_data = (rf.rs1_idx == '0) ? '0 : regs[rf.rs1_idx];
  assign rf.rs2_data = (rf.rs2_idx == '0) ? '0 : regs[rf.rs2_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rf.we && (rf.rd_idx != '0)) begin
      regs[rf.rd_idx] <= rf.rd_data;
    end
  end

endmodule

`default_nettype wire

//--- common/regfile_if.sv
/*
  register file port group
  two combinational read ports and one clocked write port
*/
`default_nettype none

interface regfile_if;
  import rv_pkg::*;

  reg_idx_t rs1_idx;
  reg_idx_t rs2_idx;
  word_t    rs1_data;
  word_t    rs2_data;
  reg_idx_t rd_idx;
  word_t    rd_data;
  logic     we;

  modport client (output rs1_idx, rs2_idx, rd_idx, rd_data, we, input rs1_data, rs2_data);
  modport rf (input rs1_idx, rs2_idx, rd_idx, rd_data, we, output rs1_data, rs2_data);

endinterface

`default_nettype wire

//--- common/rv_pkg.sv
/*
  rv32i core types
  words, register indices, instruction words, ALU operations
  and the states of the multicycle sequencer
*/
`default_nettype none

`include "rv_consts.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [4:0]          reg_idx_t;
  typedef logic [31:0]         insn_t;

  // compare members give 0 or 1 in the result word
  typedef enum logic [4:0] {
    alu_add, alu_sub, alu_sll, alu_srl, alu_sra,
    alu_slt, alu_sltu, alu_xor, alu_or, alu_and,
    alu_pass_b,
    alu_eq, alu_ne, alu_lt, alu_ge, alu_ltu, alu_geu
  } alu_op_e;

  typedef enum logic [1:0] {
    st_fetch,
    st_exec,
    st_mem,
    st_halted
  } core_state_e;

endpackage

`default_nettype wire

//--- common/rv_consts.svh
/*
  rv32i core constants
  data width, register count, first fetch address and the
  7-bit major opcodes of the base integer ISA
*/
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define RV_XLEN      32
`define RV_NUM_REGS  32
`define RV_RESET_PC  32'h0000_0000

// major opcodes, bits [6:0] of the instruction
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_IMM    7'b0010011
`define RV_OP_REG    7'b0110011
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_FENCE  7'b0001111
`define RV_OP_SYSTEM 7'b1110011

`endif
